// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wall
TOP      = tb_cache_subsys
FILELIST = cache_subsys.f

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(filter-out --binary,$(FLAGS)) --top-module $(TOP) -f $(FILELIST)

# the exit status of grep decides pass or fail.
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | grep "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: cache_subsys.f
hdl/cache_pkg.sv
hdl/icache.sv
hdl/dcache.sv
hdl/refill_arbiter.sv
hdl/line_mem.sv
hdl/cache_subsys.sv
sim/cache_subsys_assertions.sv
sim/tb_cache_subsys.sv

// File: hdl/cache_pkg.sv
package cache_pkg;

    // =========================================================================
    // line geometry
    // =========================================================================

    localparam int LINE_WORDS = 8;      // words held in one cache line.
    localparam int OFFSET_BITS = 5;     // byte offset bits inside a line.

    // =========================================================================
    // vector types
    // =========================================================================

    // byte address as seen by both CPU ports and the line memory.
    typedef logic [31:0] addr_t;

    typedef logic [31:0] word_t;        // one data or instruction word.

    // a full line, word 0 in the low bits.
    typedef logic [LINE_WORDS*32-1:0] line_t;

    typedef logic [3:0] strb_t;         // one enable per byte of a word.

    // =========================================================================
    // cache controller states
    // =========================================================================

    // IDLE serves hits and takes new requests, REFILL waits for a line
    // from memory and WRITE waits for the write-through acknowledge.
    typedef enum logic [1:0] {
        IDLE,
        REFILL,
        WRITE
    } cache_state_t;

endpackage

// File: hdl/cache_subsys.sv
`timescale 1ns/10ps

module cache_subsys #(
    parameter int ICACHE_INDEX_BITS = 4,
    parameter int DCACHE_INDEX_BITS = 4,
    parameter int MEM_LATENCY = 4,
    parameter int MEM_LINES = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetch_en,
    input  cache_pkg::addr_t fetch_addr,
    output logic             fetch_valid,
    output cache_pkg::word_t fetch_data,
    input  logic             load_en,
    input  logic             store_en,
    input  cache_pkg::addr_t data_addr,
    input  cache_pkg::strb_t store_strb,
    input  cache_pkg::word_t store_data,
    output logic             data_done,
    output cache_pkg::word_t load_data
);

    // =========================================================================
    // cache to arbiter
    // =========================================================================

    logic             ic_mem_req;
    cache_pkg::addr_t ic_mem_addr;
    logic             ic_mem_valid;
    logic             dc_mem_req;
    cache_pkg::addr_t dc_mem_addr;
    logic             dc_mem_we;
    cache_pkg::strb_t dc_mem_strb;
    cache_pkg::word_t dc_mem_wdata;
    logic             dc_mem_valid;

    // =========================================================================
    // arbiter to memory
    // =========================================================================

    logic             mem_req;
    cache_pkg::addr_t mem_addr;
    logic             mem_we;
    cache_pkg::strb_t mem_strb;
    cache_pkg::word_t mem_wdata;
    logic             mem_valid;
    cache_pkg::line_t mem_rdata;      // shared by both caches.

    icache #(
        .ICACHE_INDEX_BITS(ICACHE_INDEX_BITS)
    ) u_icache (
        .clk,
        .rst_n,
        .fetch_en,
        .fetch_addr,
        .ic_mem_valid,
        .mem_rdata,
        .fetch_valid,
        .fetch_data,
        .ic_mem_req,
        .ic_mem_addr
    );

    dcache #(
        .DCACHE_INDEX_BITS(DCACHE_INDEX_BITS)
    ) u_dcache (
        .clk,
        .rst_n,
        .load_en,
        .store_en,
        .data_addr,
        .store_strb,
        .store_data,
        .dc_mem_valid,
        .mem_rdata,
        .data_done,
        .load_data,
        .dc_mem_req,
        .dc_mem_addr,
        .dc_mem_we,
        .dc_mem_strb,
        .dc_mem_wdata
    );

    refill_arbiter u_refill_arbiter (
        .clk,
        .rst_n,
        .ic_mem_req,
        .ic_mem_addr,
        .dc_mem_req,
        .dc_mem_addr,
        .dc_mem_we,
        .dc_mem_strb,
        .dc_mem_wdata,
        .mem_valid,
        .ic_mem_valid,
        .dc_mem_valid,
        .mem_req,
        .mem_addr,
        .mem_we,
        .mem_strb,
        .mem_wdata
    );

    line_mem #(
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_LINES(MEM_LINES)
    ) u_line_mem (
        .clk,
        .mem_req,
        .mem_addr,
        .mem_we,
        .mem_strb,
        .mem_wdata,
        .mem_valid,
        .mem_rdata
    );

endmodule

// File: hdl/dcache.sv
`timescale 1ns/10ps

module dcache #(
    parameter int DCACHE_INDEX_BITS = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load_en,
    input  logic             store_en,
    input  cache_pkg::addr_t data_addr,
    input  cache_pkg::strb_t store_strb,
    input  cache_pkg::word_t store_data,
    input  logic             dc_mem_valid,
    input  cache_pkg::line_t mem_rdata,
    output logic             data_done,
    output cache_pkg::word_t load_data,
    output logic             dc_mem_req,
    output cache_pkg::addr_t dc_mem_addr,
    output logic             dc_mem_we,
    output cache_pkg::strb_t dc_mem_strb,
    output cache_pkg::word_t dc_mem_wdata
);

    localparam int SETS = 2 ** DCACHE_INDEX_BITS;
    localparam int ADDR_BITS = $bits(cache_pkg::addr_t);
    localparam int STRB_BITS = $bits(cache_pkg::strb_t);
    localparam int SEL_BITS = $clog2(cache_pkg::LINE_WORDS);
    localparam int TAG_BITS = ADDR_BITS - cache_pkg::OFFSET_BITS - DCACHE_INDEX_BITS;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [DCACHE_INDEX_BITS-1:0] index_t;
    typedef logic [SEL_BITS-1:0] sel_t;

    cache_pkg::cache_state_t state;
    logic [SETS-1:0]         valid_q;
    tag_t                    tags [SETS];
    cache_pkg::line_t        lines [SETS];
    cache_pkg::addr_t        req_addr;
    cache_pkg::strb_t        req_strb;
    cache_pkg::word_t        req_data;

    index_t           data_index;
    tag_t             data_tag;
    sel_t             data_sel;
    logic             hit;
    cache_pkg::word_t hit_word;
    index_t           req_index;
    tag_t             req_tag;
    sel_t             req_sel;

    // =========================================================================
    // address split and lookup
    // =========================================================================

    assign data_index = data_addr[cache_pkg::OFFSET_BITS +: DCACHE_INDEX_BITS];
    assign data_tag = data_addr[ADDR_BITS-1 -: TAG_BITS];
    assign data_sel = data_addr[2 +: SEL_BITS];

    assign req_index = req_addr[cache_pkg::OFFSET_BITS +: DCACHE_INDEX_BITS];
    assign req_tag = req_addr[ADDR_BITS-1 -: TAG_BITS];
    assign req_sel = req_addr[2 +: SEL_BITS];

    assign hit = valid_q[data_index] && (tags[data_index] == data_tag);
    assign hit_word = lines[data_index][32*data_sel +: 32];

    // memory side, a line read in REFILL and a word write in WRITE.
    assign dc_mem_req = (state != cache_pkg::IDLE);
    assign dc_mem_we = (state == cache_pkg::WRITE);
    assign dc_mem_addr = dc_mem_we ? {req_addr[ADDR_BITS-1:2], 2'b00}
                                   : {req_addr[ADDR_BITS-1:cache_pkg::OFFSET_BITS],
                                      {cache_pkg::OFFSET_BITS{1'b0}}};
    assign dc_mem_strb = req_strb;
    assign dc_mem_wdata = req_data;

    // =========================================================================
    // control
    // =========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_pkg::IDLE;
            valid_q <= '0;
            data_done <= 1'b0;
        end else begin
            data_done <= 1'b0;
            case (state)
                cache_pkg::IDLE: begin
                    if (load_en) begin
                        if (hit) begin
                            data_done <= 1'b1;
                        end else begin
                            state <= cache_pkg::REFILL;
                        end
                    end else if (store_en) begin
                        state <= cache_pkg::WRITE;      // every store goes to memory.
                    end
                end
                cache_pkg::REFILL: begin
                    if (dc_mem_valid) begin
                        valid_q[req_index] <= 1'b1;
                        data_done <= 1'b1;
                        state <= cache_pkg::IDLE;
                    end
                end
                cache_pkg::WRITE: begin
                    if (dc_mem_valid) begin
                        data_done <= 1'b1;
                        state <= cache_pkg::IDLE;
                    end
                end
                default: begin
                    state <= cache_pkg::IDLE;
                end
            endcase
        end
    end

    // request capture, store merge and line install.
    always_ff @(posedge clk) begin
        if (state == cache_pkg::IDLE && (load_en || store_en)) begin
            req_addr <= data_addr;
            req_strb <= store_strb;
            req_data <= store_data;
            load_data <= hit_word;
            if (store_en && hit) begin
                for (int b = 0; b < STRB_BITS; b++) begin
                    if (store_strb[b]) begin
                        lines[data_index][32*data_sel + 8*b +: 8] <= store_data[8*b +: 8];
                    end
                end
            end
        end
        if (state == cache_pkg::REFILL && dc_mem_valid) begin
            tags[req_index] <= req_tag;
            lines[req_index] <= mem_rdata;
            load_data <= mem_rdata[32*req_sel +: 32];
        end
    end

endmodule

// File: hdl/icache.sv
`timescale 1ns/10ps

module icache #(
    parameter int ICACHE_INDEX_BITS = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetch_en,
    input  cache_pkg::addr_t fetch_addr,
    input  logic             ic_mem_valid,
    input  cache_pkg::line_t mem_rdata,
    output logic             fetch_valid,
    output cache_pkg::word_t fetch_data,
    output logic             ic_mem_req,
    output cache_pkg::addr_t ic_mem_addr
);

    localparam int SETS = 2 ** ICACHE_INDEX_BITS;
    localparam int ADDR_BITS = $bits(cache_pkg::addr_t);
    localparam int SEL_BITS = $clog2(cache_pkg::LINE_WORDS);
    localparam int TAG_BITS = ADDR_BITS - cache_pkg::OFFSET_BITS - ICACHE_INDEX_BITS;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [ICACHE_INDEX_BITS-1:0] index_t;
    typedef logic [SEL_BITS-1:0] sel_t;

    cache_pkg::cache_state_t state;
    logic [SETS-1:0]         valid_q;
    tag_t                    tags [SETS];
    cache_pkg::line_t        lines [SETS];
    cache_pkg::addr_t        req_addr;

    index_t           fetch_index;
    tag_t             fetch_tag;
    sel_t             fetch_sel;
    logic             hit;
    cache_pkg::word_t hit_word;
    index_t           req_index;
    tag_t             req_tag;
    sel_t             req_sel;

    // =========================================================================
    // address split and lookup
    // =========================================================================

    assign fetch_index = fetch_addr[cache_pkg::OFFSET_BITS +: ICACHE_INDEX_BITS];
    assign fetch_tag = fetch_addr[ADDR_BITS-1 -: TAG_BITS];
    assign fetch_sel = fetch_addr[2 +: SEL_BITS];

    assign req_index = req_addr[cache_pkg::OFFSET_BITS +: ICACHE_INDEX_BITS];
    assign req_tag = req_addr[ADDR_BITS-1 -: TAG_BITS];
    assign req_sel = req_addr[2 +: SEL_BITS];

    assign hit = valid_q[fetch_index] && (tags[fetch_index] == fetch_tag);
    assign hit_word = lines[fetch_index][32*fetch_sel +: 32];

    assign ic_mem_req = (state == cache_pkg::REFILL);   // held until the line returns.
    assign ic_mem_addr = {req_addr[ADDR_BITS-1:cache_pkg::OFFSET_BITS],
                          {cache_pkg::OFFSET_BITS{1'b0}}};

    // =========================================================================
    // control
    // =========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_pkg::IDLE;
            valid_q <= '0;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b0;
            case (state)
                cache_pkg::IDLE: begin
                    if (fetch_en) begin
                        if (hit) begin
                            fetch_valid <= 1'b1;
                        end else begin
                            state <= cache_pkg::REFILL;
                        end
                    end
                end
                cache_pkg::REFILL: begin
                    if (ic_mem_valid) begin
                        valid_q[req_index] <= 1'b1;
                        fetch_valid <= 1'b1;            // answer straight from the new line.
                        state <= cache_pkg::IDLE;
                    end
                end
                default: begin
                    state <= cache_pkg::IDLE;
                end
            endcase
        end
    end

    // tag, line and word storage.
    always_ff @(posedge clk) begin
        if (state == cache_pkg::IDLE && fetch_en) begin
            req_addr <= fetch_addr;
            fetch_data <= hit_word;                     // only seen when it was a hit.
        end
        if (state == cache_pkg::REFILL && ic_mem_valid) begin
            tags[req_index] <= req_tag;
            lines[req_index] <= mem_rdata;
            fetch_data <= mem_rdata[32*req_sel +: 32];
        end
    end

endmodule

// File: hdl/line_mem.sv
`timescale 1ns/10ps

module line_mem #(
    parameter int MEM_LATENCY = 4,
    parameter int MEM_LINES = 64
) (
    input  logic             clk,
    input  logic             mem_req,
    input  cache_pkg::addr_t mem_addr,
    input  logic             mem_we,
    input  cache_pkg::strb_t mem_strb,
    input  cache_pkg::word_t mem_wdata,
    output logic             mem_valid,
    output cache_pkg::line_t mem_rdata
);

    localparam int LINE_INDEX_BITS = $clog2(MEM_LINES);
    localparam int SEL_BITS = $clog2(cache_pkg::LINE_WORDS);
    localparam int STRB_BITS = $bits(cache_pkg::strb_t);
    localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

    typedef logic [LINE_INDEX_BITS-1:0] line_index_t;

    cache_pkg::line_t     mem [MEM_LINES];
    logic [CNT_BITS-1:0]  cnt = '0;       // cycles left until the response.
    line_index_t          rd_index;
    line_index_t          req_index;
    logic [SEL_BITS-1:0]  req_sel;

    // the line index wraps with the memory size.
    assign req_index = mem_addr[cache_pkg::OFFSET_BITS +: LINE_INDEX_BITS];
    assign req_sel = mem_addr[2 +: SEL_BITS];

    assign mem_valid = (cnt == CNT_BITS'(1));
    assign mem_rdata = mem[rd_index];

    // known contents, word i holds i times the golden ratio constant.
    initial begin
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < cache_pkg::LINE_WORDS; w++) begin
                mem[l][32*w +: 32] = cache_pkg::word_t'(l * cache_pkg::LINE_WORDS + w)
                                     * 32'h9E3779B9;
            end
        end
    end

    always @(posedge clk) begin
        if (mem_req) begin
            cnt <= CNT_BITS'(MEM_LATENCY);
            rd_index <= req_index;
            if (mem_we) begin
                for (int b = 0; b < STRB_BITS; b++) begin
                    if (mem_strb[b]) begin
                        mem[req_index][32*req_sel + 8*b +: 8] <= mem_wdata[8*b +: 8];
                    end
                end
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

// File: hdl/refill_arbiter.sv
`timescale 1ns/10ps

module refill_arbiter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ic_mem_req,
    input  cache_pkg::addr_t ic_mem_addr,
    input  logic             dc_mem_req,
    input  cache_pkg::addr_t dc_mem_addr,
    input  logic             dc_mem_we,
    input  cache_pkg::strb_t dc_mem_strb,
    input  cache_pkg::word_t dc_mem_wdata,
    input  logic             mem_valid,
    output logic             ic_mem_valid,
    output logic             dc_mem_valid,
    output logic             mem_req,
    output cache_pkg::addr_t mem_addr,
    output logic             mem_we,
    output cache_pkg::strb_t mem_strb,
    output cache_pkg::word_t mem_wdata
);

    logic busy;         // a transaction is in flight.
    logic owner_dc;     // owner of that transaction, 1 for the dcache.
    logic last_dc;      // last grant went to the dcache.

    logic mem_idle;
    logic ic_pending;
    logic dc_pending;
    logic grant_dc;

    // the memory can take a new request in the cycle its response returns.
    assign mem_idle = !busy || mem_valid;

    // the owner still holds its request level while its response is returning.
    assign ic_pending = ic_mem_req && !(busy && !owner_dc);
    assign dc_pending = dc_mem_req && !(busy && owner_dc);

    assign grant_dc = dc_pending && (!ic_pending || !last_dc);

    assign mem_req = mem_idle && (ic_pending || dc_pending);
    assign mem_addr = grant_dc ? dc_mem_addr : ic_mem_addr;
    assign mem_we = grant_dc && dc_mem_we;
    assign mem_strb = dc_mem_strb;
    assign mem_wdata = dc_mem_wdata;

    assign ic_mem_valid = mem_valid && !owner_dc;
    assign dc_mem_valid = mem_valid && owner_dc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            owner_dc <= 1'b0;
            last_dc <= 1'b1;    // so the icache wins the first tie.
        end else if (mem_req) begin
            busy <= 1'b1;
            owner_dc <= grant_dc;
            last_dc <= grant_dc;
        end else if (mem_valid) begin
            busy <= 1'b0;
        end
    end

endmodule

// File: sim/cache_subsys_assertions.sv
`timescale 1ns/10ps

module cache_subsys_assertions (
    input logic clk,
    input logic rst_n,
    input logic mem_req,
    input logic mem_valid,
    input logic fetch_valid,
    input logic data_done,
    input logic load_en,
    input logic store_en
);

    logic in_flight;    // a memory request was issued and has not been answered.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else if (mem_req) begin
            in_flight <= 1'b1;
        end else if (mem_valid) begin
            in_flight <= 1'b0;
        end
    end

    // ==========================================================================
    // strobe protocol
    // ==========================================================================

    valid_needs_request: assert property (
        @(posedge clk) disable iff (!rst_n) mem_valid |-> in_flight
    ) else $error("mem_valid without a memory request in flight");

    fetch_valid_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) fetch_valid |=> !fetch_valid
    ) else $error("fetch_valid held longer than one cycle");

    data_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) data_done |=> !data_done
    ) else $error("data_done held longer than one cycle");

    load_store_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(load_en && store_en)
    ) else $error("load_en and store_en high together");

endmodule

bind cache_subsys cache_subsys_assertions assertions_i (.*);

// File: sim/tb_cache_subsys.sv
`timescale 1ns/10ps

module tb_cache_subsys;

    localparam int ICACHE_INDEX_BITS = 4;
    localparam int DCACHE_INDEX_BITS = 4;
    localparam int MEM_LATENCY = 4;
    localparam int MEM_LINES = 64;
    localparam int MODEL_WORDS = MEM_LINES * cache_pkg::LINE_WORDS;
    localparam int HALF_WORDS = MODEL_WORDS / 2;
    localparam int N_FETCH = 160;
    localparam int N_DATA = 160;
    localparam int N_DIRECTED = 8;
    localparam int N_TXN = N_FETCH + 2 * N_DATA + N_DIRECTED;  // a store brings its own load.
    localparam int TIMEOUT_CYCLES = N_TXN * (MEM_LATENCY + 10) * 2;

    logic             clk;
    logic             rst_n;
    logic             fetch_en;
    cache_pkg::addr_t fetch_addr;
    logic             fetch_valid;
    cache_pkg::word_t fetch_data;
    logic             load_en;
    logic             store_en;
    cache_pkg::addr_t data_addr;
    cache_pkg::strb_t store_strb;
    cache_pkg::word_t store_data;
    logic             data_done;
    cache_pkg::word_t load_data;

    cache_pkg::word_t model_mem [MODEL_WORDS];  // memory contents as the CPU should see them.
    cache_pkg::addr_t fetch_list [N_FETCH];
    cache_pkg::addr_t data_list [N_DATA];
    logic             is_store [N_DATA];
    cache_pkg::strb_t strb_list [N_DATA];
    cache_pkg::word_t wdata_list [N_DATA];
    logic [31:0]      rng;

    cache_subsys #(
        .ICACHE_INDEX_BITS(ICACHE_INDEX_BITS),
        .DCACHE_INDEX_BITS(DCACHE_INDEX_BITS),
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_LINES(MEM_LINES)
    ) dut_i (
        .clk, .rst_n, .fetch_en, .fetch_addr, .fetch_valid, .fetch_data,
        .load_en, .store_en, .data_addr, .store_strb, .store_data, .data_done, .load_data
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==========================================================================
    // reference model
    // ==========================================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int word_index(input cache_pkg::addr_t addr);
        return int'((addr >> 2) % MODEL_WORDS);     // the memory wraps at its size.
    endfunction

    function automatic cache_pkg::word_t initial_word(input cache_pkg::addr_t addr);
        logic [31:0] index;
        index = (addr >> 2) % MODEL_WORDS;
        return index * 32'h9E3779B9;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ==========================================================================
    // CPU side transactions
    // ==========================================================================

    task automatic do_fetch(input cache_pkg::addr_t addr);
        fetch_addr = addr;
        fetch_en = 1'b1;
        @(negedge clk);
        fetch_en = 1'b0;
        while (!fetch_valid) @(negedge clk);
        check_value("fetch_data", model_mem[word_index(addr)], fetch_data);
        @(negedge clk);                             // lets the pulse drop before the next fetch.
    endtask

    task automatic do_load(input cache_pkg::addr_t addr, input logic expect_hit);
        data_addr = addr;
        load_en = 1'b1;
        @(negedge clk);
        load_en = 1'b0;
        if (expect_hit) check_value("data_done", 32'h1, {31'b0, data_done});
        while (!data_done) @(negedge clk);
        check_value("load_data", model_mem[word_index(addr)], load_data);
        @(negedge clk);
    endtask

    task automatic do_store(input cache_pkg::addr_t addr, input cache_pkg::strb_t strb,
                            input cache_pkg::word_t data);
        int idx;
        data_addr = addr;
        store_strb = strb;
        store_data = data;
        store_en = 1'b1;
        @(negedge clk);
        store_en = 1'b0;
        while (!data_done) @(negedge clk);
        idx = word_index(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) model_mem[idx][8*b +: 8] = data[8*b +: 8];
        end
        @(negedge clk);
    endtask

    // ==========================================================================
    // watchdog
    // ==========================================================================

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Error: the run timed out after %0d cycles with requests pending",
                 TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n = 1'b0;
        fetch_en = 1'b0;
        fetch_addr = '0;
        load_en = 1'b0;
        store_en = 1'b0;
        data_addr = '0;
        store_strb = '0;
        store_data = '0;
        for (int i = 0; i < MODEL_WORDS; i++) model_mem[i] = initial_word(32'(i) << 2);
        rng = 32'h6025;
        for (int i = 0; i < N_FETCH; i++) begin
            rng = xorshift32(rng);
            fetch_list[i] = (rng % HALF_WORDS) << 2;    // fetches stay in the lower half.
        end
        for (int i = 0; i < N_DATA; i++) begin
            rng = xorshift32(rng);
            data_list[i] = (HALF_WORDS + (rng >> 1) % HALF_WORDS) << 2;
            is_store[i] = rng[0];
            strb_list[i] = rng[8 +: 4];
            rng = xorshift32(rng);
            wdata_list[i] = rng;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        fork
            begin
                for (int i = 0; i < N_FETCH; i++) do_fetch(fetch_list[i]);
            end
            begin
                do_load(32'h468, 1'b0);
                do_load(32'h468, 1'b1);                 // hits the line refilled just above.
                do_store(32'h46C, 4'b0101, 32'hCAFE_F00D);
                do_load(32'h46C, 1'b1);
                do_load(32'h66C, 1'b0);                 // maps to the same set and evicts it.
                do_load(32'h46C, 1'b0);
                do_store(32'h7E4, 4'b1010, 32'h1234_5678);
                do_load(32'h7E4, 1'b0);
                for (int i = 0; i < N_DATA; i++) begin
                    if (is_store[i]) begin
                        do_store(data_list[i], strb_list[i], wdata_list[i]);
                        do_load(data_list[i], 1'b0);
                    end else begin
                        do_load(data_list[i], 1'b0);
                    end
                end
            end
        join
        $display("STATUS: PASS");
        $finish;
    end

endmodule
